// ==== sim.f ====
src/chirp_pkg.sv
src/chirp_nco.sv
src/adc_loopback.sv
src/capture_ctrl.sv
src/sample_router.sv
src/credit_tx_fifo.sv
src/chirp_capture_top.sv
tb/tb_chirp_capture.sv

// ==== Makefile ====
SRCS := $(wildcard src/*.sv) $(wildcard tb/*.sv)

.PHONY: run clean

obj_dir/Vtb_chirp_capture: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module tb_chirp_capture -Mdir obj_dir -o Vtb_chirp_capture

run: obj_dir/Vtb_chirp_capture
	./obj_dir/Vtb_chirp_capture

clean:
	rm -rf obj_dir

// ==== tb/tb_chirp_capture.sv ====
`timescale 1ns/100ps

module tb_chirp_capture import chirp_pkg::*; ();

  localparam int dds_latency = 2;
  localparam int adc_delay   = 100;
  localparam int fifo_depth  = 64;
  localparam int tx_credits  = 8;

  logic   clk_245_76MHz;
  logic   cpu_reset;
  logic   adc_enable_i;
  logic   chirp_init_i;
  logic   chirp_enable_i;
  count_t chirp_control_word_i;
  count_t chirp_freq_offset_i;
  count_t chirp_tuning_word_coeff_i;
  count_t chirp_count_max_i;
  logic   credit_i;
  logic   chirp_ready_o;
  logic   chirp_active_o;
  logic   chirp_done_o;
  logic   out_valid_o;
  word_t  out_word_o;
  logic   out_last_o;
  logic   overflow_o;

  // words of the frame under test, header first
  word_t       frame_q[$];

  chirp_capture_top #(
    .dds_latency(dds_latency), .adc_delay(adc_delay),
    .fifo_depth(fifo_depth), .tx_credits(tx_credits)
  ) i_dut (.*);

  initial begin
    clk_245_76MHz = 1'b0;
    forever #20 clk_245_76MHz = ~clk_245_76MHz;
  end

  task automatic stop_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic flag_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic abort_stall(input string what);
    $display("gave up at %0t ns waiting for %s", $time, what);
    stop_run();
  endtask

  // capture enable high for n rising edges
  task automatic drive_frame(input int n);
    @(negedge clk_245_76MHz);
    adc_enable_i = 1'b1;
    repeat (n) @(negedge clk_245_76MHz);
    adc_enable_i = 1'b0;
  endtask

  // credit back every cycle, keep words up to the trailer
  task automatic collect_frame(input int limit);
    int waited;
    waited = 0;
    do begin
      @(negedge clk_245_76MHz);
      credit_i = 1'b1;
      if (out_valid_o) frame_q.push_back(out_word_o);
      waited++;
      if (waited > limit) abort_stall("the trailer word");
    end while (!(out_valid_o && out_last_o));
  endtask

  // no credits back, words that still leave are kept
  task automatic hold_credits(input int cycles);
    repeat (cycles) begin
      @(negedge clk_245_76MHz);
      credit_i = 1'b0;
      if (out_valid_o) frame_q.push_back(out_word_o);
    end
  endtask

  task automatic arm_chirp(input count_t offset, input count_t coeff, input count_t len);
    @(negedge clk_245_76MHz);
    chirp_freq_offset_i       = offset;
    chirp_tuning_word_coeff_i = coeff;
    chirp_count_max_i         = len;
    chirp_init_i              = 1'b1;
    @(negedge clk_245_76MHz);
    chirp_init_i = 1'b0;
    assert (chirp_ready_o) else flag_mismatch("chirp_ready_o low after chirp_init_i");
  endtask

  // one cycle start pulse, returns on the first active cycle
  task automatic fire_chirp();
    @(negedge clk_245_76MHz);
    chirp_enable_i = 1'b1;
    @(negedge clk_245_76MHz);
    chirp_enable_i = 1'b0;
  endtask

  task automatic reset_outputs_low();
    assert (!out_valid_o && !overflow_o && !chirp_ready_o && !chirp_active_o && !chirp_done_o)
      else flag_mismatch("outputs not all low after reset");
    repeat (20) begin
      @(negedge clk_245_76MHz);
      assert (!out_valid_o) else flag_mismatch("word left the fifo with no frame open");
    end
  endtask

  task automatic counter_frames();
    int     n;
    count_t prev_last;
    // both halves carry the adc sample count
    chirp_control_word_i = 32'h22;
    prev_last = '0;
    for (int f = 0; f < 2; f++) begin
      n = 10 + int'($urandom % 21);
      frame_q.delete();
      fork
        drive_frame(n);
        collect_frame(n + 40);
      join
      assert (frame_q.size() == n + dds_latency)
        else flag_mismatch($sformatf("frame of %0d words, held %0d", frame_q.size(), n));
      // header and trailer timestamps one cycle apart per word
      assert (frame_q[$][63:32] - frame_q[0][63:32] == count_t'(frame_q.size() - 1))
        else flag_mismatch("global counter span does not match frame length");
      if (f == 1) begin
        assert (frame_q[0][31:0] == prev_last + 1)
          else flag_mismatch("adc count did not continue from the previous frame");
      end
      for (int k = 1; k < frame_q.size(); k++) begin
        assert (frame_q[k][31:0] == frame_q[k-1][31:0] + 1)
          else flag_mismatch($sformatf("adc count step broken at word %0d", k));
        if (k < frame_q.size() - 1) begin
          assert (frame_q[k][63:32] == frame_q[k][31:0])
            else flag_mismatch($sformatf("upper half differs at word %0d", k));
        end
      end
      prev_last = frame_q[$][31:0];
    end
  endtask

  task automatic chirp_handshake();
    int active_cycles;
    int done_pulses;
    int len;
    len = 5 + int'($urandom % 20);
    assert (!chirp_ready_o) else flag_mismatch("chirp_ready_o high before chirp_init_i");
    arm_chirp('0, '0, count_t'(len));
    repeat (3) begin
      @(negedge clk_245_76MHz);
      assert (chirp_ready_o && !chirp_active_o) else flag_mismatch("armed state not held");
    end
    fire_chirp();
    active_cycles = 0;
    done_pulses   = 0;
    // window covers the run and the done cycle
    for (int k = 0; k < len + 10; k++) begin
      if (chirp_active_o) active_cycles++;
      if (chirp_done_o) done_pulses++;
      @(negedge clk_245_76MHz);
    end
    assert (active_cycles == len)
      else flag_mismatch($sformatf("active for %0d cycles, wanted %0d", active_cycles, len));
    assert (done_pulses == 1)
      else flag_mismatch($sformatf("chirp_done_o pulsed %0d times", done_pulses));
    assert (!chirp_ready_o) else flag_mismatch("chirp_ready_o still high after the run");
  endtask

  task automatic dac_ramp();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] d2;
    int          start;
    int          len;
    a   = 16'(1 + $urandom % 255);
    b   = 16'(1 + $urandom % 63);
    len = 24;
    // dac pair on top, sample count below
    chirp_control_word_i = 32'h12;
    arm_chirp({a, 16'h0}, {b, 16'h0}, count_t'(len));
    // phase now zero, let it reach the dac
    repeat (8) @(negedge clk_245_76MHz);
    frame_q.delete();
    fork
      drive_frame(len + 30);
      begin
        repeat (5) @(negedge clk_245_76MHz);
        fire_chirp();
      end
      collect_frame(len + 80);
    join
    // ramp starts one word before the first nonzero I
    start = -1;
    for (int k = frame_q.size() - 2; k >= 1; k--) begin
      if (frame_q[k][63:48] != 16'h0) start = k - 1;
    end
    assert (start >= 1 && start + len < frame_q.size() - 1)
      else flag_mismatch("chirp ramp not inside the frame");
    for (int k = 0; k < len - 1; k++) begin
      d2 = frame_q[start+k+2][63:48] - 16'(2 * frame_q[start+k+1][63:48])
           + frame_q[start+k][63:48];
      assert (d2 == b)
        else flag_mismatch($sformatf("second difference %0d, wanted %0d", d2, b));
    end
    for (int k = 1; k < frame_q.size() - 1; k++) begin
      assert (frame_q[k][47:32] == 16'(frame_q[k][63:48] + 16'd16384))
        else flag_mismatch($sformatf("Q not a quarter turn ahead at word %0d", k));
    end
  endtask

  task automatic adc_echo();
    sample_t di;
    sample_t dq;
    // dac on top, adc below
    chirp_control_word_i = 32'h10;
    arm_chirp({16'(1 + $urandom % 255), 16'h0}, {16'(1 + $urandom % 63), 16'h0}, 150);
    repeat (8) @(negedge clk_245_76MHz);
    frame_q.delete();
    fork
      drive_frame(adc_delay + 40);
      begin
        repeat (3) @(negedge clk_245_76MHz);
        fire_chirp();
      end
      collect_frame(adc_delay + 100);
    join
    for (int k = 1 + adc_delay; k < frame_q.size() - 1; k++) begin
      di = frame_q[k-adc_delay][63:48];
      dq = frame_q[k-adc_delay][47:32];
      assert (frame_q[k][31:16] == 16'(di >>> 1) && frame_q[k][15:0] == 16'(dq >>> 1))
        else flag_mismatch($sformatf("adc pair at word %0d is not the halved echo", k));
    end
  endtask

  task automatic credit_back_pressure();
    int waited;
    chirp_control_word_i = 32'h22;
    frame_q.delete();
    fork
      drive_frame(20 - dds_latency);
      hold_credits(60);
    join
    assert (frame_q.size() <= tx_credits)
      else flag_mismatch($sformatf("%0d words left with credits withheld", frame_q.size()));
    assert (!overflow_o) else flag_mismatch("overflow_o set by a frame that fits");
    collect_frame(100);
    assert (frame_q.size() == 20)
      else flag_mismatch($sformatf("got %0d of 20 words", frame_q.size()));
    for (int k = 1; k < frame_q.size(); k++) begin
      assert (frame_q[k][31:0] == frame_q[k-1][31:0] + 1)
        else flag_mismatch($sformatf("word %0d out of order", k));
    end
    // now more than the fifo plus the credit pool
    waited = 0;
    fork
      drive_frame(fifo_depth + tx_credits + 10);
      while (!overflow_o) begin
        @(negedge clk_245_76MHz);
        credit_i = 1'b0;
        waited++;
        if (waited > 300) abort_stall("overflow_o to rise");
      end
    join
  endtask

  initial begin
    void'($urandom(35));
    cpu_reset                 = 1'b1;
    adc_enable_i              = 1'b0;
    chirp_init_i              = 1'b0;
    chirp_enable_i            = 1'b0;
    chirp_control_word_i      = '0;
    chirp_freq_offset_i       = '0;
    chirp_tuning_word_coeff_i = '0;
    chirp_count_max_i         = '0;
    credit_i                  = 1'b0;
    repeat (8) @(negedge clk_245_76MHz);
    cpu_reset = 1'b0;
    credit_i  = 1'b1;
    reset_outputs_low();
    counter_frames();
    chirp_handshake();
    dac_ramp();
    adc_echo();
    credit_back_pressure();
    $display("sim passed");
    $finish;
  end

endmodule

// ==== src/chirp_capture_top.sv ====
`timescale 1ns/100ps

module chirp_capture_top import chirp_pkg::*; #(
  parameter int dds_latency = 2,
  parameter int adc_delay   = 100,
  parameter int fifo_depth  = 64,
  parameter int tx_credits  = 8
) (
  input  logic   clk_245_76MHz,
  input  logic   cpu_reset,
  input  logic   adc_enable_i,
  input  logic   chirp_init_i,
  input  logic   chirp_enable_i,
  input  count_t chirp_control_word_i,
  input  count_t chirp_freq_offset_i,
  input  count_t chirp_tuning_word_coeff_i,
  input  count_t chirp_count_max_i,
  input  logic   credit_i,
  output logic   chirp_ready_o,
  output logic   chirp_active_o,
  output logic   chirp_done_o,
  output logic   out_valid_o,
  output word_t  out_word_o,
  output logic   out_last_o,
  output logic   overflow_o
);

  // nco to dac
  sample_t nco_i;
  sample_t nco_q;
  // loopback to router
  iq_t     dac_iq;
  iq_t     adc_iq;
  logic    sample_valid;
  // capture control
  logic    wr_en;
  logic    frame_first;
  logic    frame_last;
  count_t  adc_count;
  count_t  glbl_count;
  // router to fifo
  word_t   wr_word;
  logic    wr_last;

  // nco valid not needed, the adc side runs continuously
  chirp_nco #(.dds_latency(dds_latency)) i_chirp_nco (
    .clk_245_76MHz(clk_245_76MHz), .cpu_reset(cpu_reset),
    .chirp_init_i(chirp_init_i), .chirp_enable_i(chirp_enable_i),
    .chirp_freq_offset_i(chirp_freq_offset_i),
    .chirp_tuning_word_coeff_i(chirp_tuning_word_coeff_i),
    .chirp_count_max_i(chirp_count_max_i),
    .chirp_ready_o(chirp_ready_o), .chirp_active_o(chirp_active_o),
    .chirp_done_o(chirp_done_o),
    .nco_i_o(nco_i), .nco_q_o(nco_q), .nco_valid_o()
  );

  adc_loopback #(.adc_delay(adc_delay)) i_adc_loopback (
    .clk_245_76MHz(clk_245_76MHz), .cpu_reset(cpu_reset),
    .nco_i_i(nco_i), .nco_q_i(nco_q),
    .dac_iq_o(dac_iq), .adc_iq_o(adc_iq), .sample_valid_o(sample_valid)
  );

  capture_ctrl #(.dds_latency(dds_latency)) i_capture_ctrl (
    .clk_245_76MHz(clk_245_76MHz), .cpu_reset(cpu_reset),
    .adc_enable_i(adc_enable_i), .chirp_init_i(chirp_init_i),
    .sample_valid_i(sample_valid), .wr_en_o(wr_en),
    .frame_first_o(frame_first), .frame_last_o(frame_last),
    .adc_count_o(adc_count), .glbl_count_o(glbl_count)
  );

  sample_router i_sample_router (
    .chirp_control_word_i(chirp_control_word_i),
    .adc_iq_i(adc_iq), .dac_iq_i(dac_iq),
    .adc_count_i(adc_count), .glbl_count_i(glbl_count),
    .frame_first_i(frame_first), .frame_last_i(frame_last),
    .wr_word_o(wr_word), .wr_last_o(wr_last)
  );

  credit_tx_fifo #(.fifo_depth(fifo_depth), .tx_credits(tx_credits)) i_credit_tx_fifo (
    .clk_245_76MHz(clk_245_76MHz), .cpu_reset(cpu_reset),
    .wr_en_i(wr_en), .wr_word_i(wr_word), .wr_last_i(wr_last),
    .credit_i(credit_i), .out_valid_o(out_valid_o), .out_word_o(out_word_o),
    .out_last_o(out_last_o), .overflow_o(overflow_o)
  );

endmodule

// ==== src/credit_tx_fifo.sv ====
`timescale 1ns/100ps

module credit_tx_fifo import chirp_pkg::*; #(
  parameter int fifo_depth = 64,
  parameter int tx_credits = 8
) (
  input  logic  clk_245_76MHz,
  input  logic  cpu_reset,
  input  logic  wr_en_i,
  input  word_t wr_word_i,
  input  logic  wr_last_i,
  input  logic  credit_i,
  output logic  out_valid_o,
  output word_t out_word_o,
  output logic  out_last_o,
  output logic  overflow_o
);

  localparam int ptr_w  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w  = $clog2(fifo_depth + 1);
  localparam int cred_w = $clog2(tx_credits + 1);

  // storage, last flag kept above the word
  logic [64:0]       mem [fifo_depth];
  logic [ptr_w-1:0]  wr_ptr_q;
  logic [ptr_w-1:0]  rd_ptr_q;
  logic [cnt_w-1:0]  fill_q;
  logic [cred_w-1:0] credit_q;
  logic              full;
  logic              push;
  logic              pop;

  assign full = (fill_q == cnt_w'(fifo_depth));
  assign push = wr_en_i && !full;
  // read only with data waiting and a credit in hand
  assign pop  = (fill_q != '0) && (credit_q != '0);

  always_ff @(posedge clk_245_76MHz) begin
    if (push) mem[wr_ptr_q] <= {wr_last_i, wr_word_i};
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fill_q     <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      fill_q <= fill_q + cnt_w'(push) - cnt_w'(pop);
      // dropped word, flag stays until reset
      if (wr_en_i && full) overflow_o <= 1'b1;
    end
  end

  // credit pool, capped at its starting size
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      credit_q <= cred_w'(tx_credits);
    end else if (credit_i && !pop) begin
      if (credit_q != cred_w'(tx_credits)) credit_q <= credit_q + 1'b1;
    end else if (!credit_i && pop) begin
      credit_q <= credit_q - 1'b1;
    end
  end

  // registered output stage
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= pop;
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (pop) {out_last_o, out_word_o} <= mem[rd_ptr_q];
  end

endmodule

// ==== src/sample_router.sv ====
`timescale 1ns/100ps

module sample_router import chirp_pkg::*; (
  input  count_t chirp_control_word_i,
  input  iq_t    adc_iq_i,
  input  iq_t    dac_iq_i,
  input  count_t adc_count_i,
  input  count_t glbl_count_i,
  input  logic   frame_first_i,
  input  logic   frame_last_i,
  output word_t  wr_word_o,
  output logic   wr_last_o
);

  route_t sel_lower;
  route_t sel_upper;
  count_t half_lower;
  count_t half_upper;

  // same mux for both halves
  function automatic count_t pick(route_t sel, iq_t adc_iq, iq_t dac_iq,
                                  count_t adc_cnt, count_t glbl_cnt);
    case (sel)
      route_adc:        pick = adc_iq;
      route_dac:        pick = dac_iq;
      route_adc_count:  pick = adc_cnt;
      route_glbl_count: pick = glbl_cnt;
    endcase
  endfunction

  assign sel_lower = chirp_control_word_i[1:0];
  assign sel_upper = chirp_control_word_i[5:4];

  assign half_lower = pick(sel_lower, adc_iq_i, dac_iq_i, adc_count_i, glbl_count_i);
  assign half_upper = pick(sel_upper, adc_iq_i, dac_iq_i, adc_count_i, glbl_count_i);

  // header and trailer carry timestamp and sample count
  assign wr_word_o = (frame_first_i || frame_last_i) ? {glbl_count_i, adc_count_i}
                                                      : {half_upper, half_lower};
  assign wr_last_o = frame_last_i;

endmodule

// ==== src/capture_ctrl.sv ====
`timescale 1ns/100ps

module capture_ctrl import chirp_pkg::*; #(
  parameter int dds_latency = 2
) (
  input  logic   clk_245_76MHz,
  input  logic   cpu_reset,
  input  logic   adc_enable_i,
  input  logic   chirp_init_i,
  input  logic   sample_valid_i,
  output logic   wr_en_o,
  output logic   frame_first_o,
  output logic   frame_last_o,
  output count_t adc_count_o,
  output count_t glbl_count_o
);

  localparam int drain_w = $clog2(dds_latency + 1);

  // registered enable
  logic               enable_r;
  // frame open, only updated once the drain is done
  logic               enable_rr;
  logic [drain_w-1:0] drain_cnt_q;
  logic               drain_idle;
  logic               first_q;
  count_t             adc_cnt_q;
  count_t             glbl_cnt_q;

  assign drain_idle = (drain_cnt_q == '0);

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_r  <= 1'b0;
      enable_rr <= 1'b0;
    end else begin
      enable_r <= adc_enable_i;
      if (drain_idle) enable_rr <= enable_r;
    end
  end

  // drain covers samples still inside the dds pipeline
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      drain_cnt_q <= '0;
    end else if (chirp_init_i || (enable_r && !adc_enable_i)) begin
      drain_cnt_q <= drain_w'(dds_latency);
    end else if (!drain_idle) begin
      drain_cnt_q <= drain_cnt_q - 1'b1;
    end
  end

  // header flag, lines up with the first write
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      first_q <= 1'b0;
    end else begin
      first_q <= drain_idle && enable_r && !enable_rr;
    end
  end

  assign wr_en_o       = enable_rr && sample_valid_i;
  assign frame_first_o = first_q;
  // final write of the frame carries the trailer
  assign frame_last_o  = drain_idle && enable_rr && !enable_r;

  // sample counter, only on written cycles
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      adc_cnt_q <= '0;
    end else if (wr_en_o) begin
      adc_cnt_q <= adc_cnt_q + count_t'(1);
    end
  end

  // free-running cycle counter
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      glbl_cnt_q <= '0;
    end else begin
      glbl_cnt_q <= glbl_cnt_q + count_t'(1);
    end
  end

  assign adc_count_o  = adc_cnt_q;
  assign glbl_count_o = glbl_cnt_q;

endmodule

// ==== src/adc_loopback.sv ====
`timescale 1ns/100ps

module adc_loopback import chirp_pkg::*; #(
  parameter int adc_delay = 100
) (
  input  logic    clk_245_76MHz,
  input  logic    cpu_reset,
  input  sample_t nco_i_i,
  input  sample_t nco_q_i,
  output iq_t     dac_iq_o,
  output iq_t     adc_iq_o,
  output logic    sample_valid_o
);

  // two register stages on the dac side
  sample_t dac_i_r;
  sample_t dac_q_r;
  sample_t dac_i_rr;
  sample_t dac_q_rr;

  // return path, one entry per cycle of flight time
  iq_t delay_q [adc_delay];

  always_ff @(posedge clk_245_76MHz) begin
    dac_i_r  <= nco_i_i;
    dac_q_r  <= nco_q_i;
    dac_i_rr <= dac_i_r;
    dac_q_rr <= dac_q_r;
  end

  assign dac_iq_o = {dac_i_rr, dac_q_rr};

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      for (int k = 0; k < adc_delay; k++) delay_q[k] <= '0;
    end else begin
      // echo comes back at half amplitude, sign kept
      delay_q[0] <= {dac_i_rr >>> 1, dac_q_rr >>> 1};
      for (int k = 1; k < adc_delay; k++) delay_q[k] <= delay_q[k-1];
    end
  end

  assign adc_iq_o = delay_q[adc_delay-1];

  // adc always delivers once out of reset
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_valid_o <= 1'b0;
    end else begin
      sample_valid_o <= 1'b1;
    end
  end

endmodule

// ==== src/chirp_nco.sv ====
`timescale 1ns/100ps

module chirp_nco import chirp_pkg::*; #(
  parameter int dds_latency = 2
) (
  input  logic    clk_245_76MHz,
  input  logic    cpu_reset,
  input  logic    chirp_init_i,
  input  logic    chirp_enable_i,
  input  count_t  chirp_freq_offset_i,
  input  count_t  chirp_tuning_word_coeff_i,
  input  count_t  chirp_count_max_i,
  output logic    chirp_ready_o,
  output logic    chirp_active_o,
  output logic    chirp_done_o,
  output sample_t nco_i_o,
  output sample_t nco_q_o,
  output logic    nco_valid_o
);

  chirp_state_e state_q;
  count_t       run_cnt_q;
  phase_t       phase_q;
  phase_t       tuning_q;

  sample_t raw_i;
  sample_t raw_q;

  // output pipeline, stands in for the dds core latency
  sample_t pipe_i [dds_latency];
  sample_t pipe_q [dds_latency];
  logic    pipe_v [dds_latency];

  // state machine
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      state_q   <= chirp_idle;
      run_cnt_q <= '0;
    end else begin
      case (state_q)
        chirp_idle: begin
          if (chirp_init_i) state_q <= chirp_armed;
        end
        chirp_armed: begin
          run_cnt_q <= '0;
          if (chirp_enable_i) state_q <= chirp_run;
        end
        chirp_run: begin
          run_cnt_q <= run_cnt_q + count_t'(1);
          // last active cycle when count hits max-1
          if (run_cnt_q == chirp_count_max_i - count_t'(1)) state_q <= chirp_done;
        end
        default: begin
          // done lasts a single cycle
          state_q <= chirp_idle;
        end
      endcase
    end
  end

  // phase accumulator with a linearly growing tuning word
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      phase_q  <= '0;
      tuning_q <= '0;
    end else if (state_q == chirp_armed) begin
      // load start frequency, phase restarts at zero
      phase_q  <= '0;
      tuning_q <= chirp_freq_offset_i;
    end else if (state_q == chirp_run) begin
      phase_q  <= phase_q + tuning_q;
      tuning_q <= tuning_q + chirp_tuning_word_coeff_i;
    end
  end

  // phase ramp in place of a sine table
  assign raw_i = phase_q[31:16];
  // Q leads by a quarter turn
  assign raw_q = raw_i + sample_t'(16384);

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      for (int k = 0; k < dds_latency; k++) begin
        pipe_i[k] <= '0;
        pipe_q[k] <= '0;
        pipe_v[k] <= 1'b0;
      end
    end else begin
      pipe_i[0] <= raw_i;
      pipe_q[0] <= raw_q;
      pipe_v[0] <= (state_q == chirp_run);
      for (int k = 1; k < dds_latency; k++) begin
        pipe_i[k] <= pipe_i[k-1];
        pipe_q[k] <= pipe_q[k-1];
        pipe_v[k] <= pipe_v[k-1];
      end
    end
  end

  assign nco_i_o     = pipe_i[dds_latency-1];
  assign nco_q_o     = pipe_q[dds_latency-1];
  assign nco_valid_o = pipe_v[dds_latency-1];

  // status straight from the state register
  assign chirp_ready_o  = (state_q == chirp_armed);
  assign chirp_active_o = (state_q == chirp_run);
  assign chirp_done_o   = (state_q == chirp_done);

endmodule

// ==== src/chirp_pkg.sv ====
package chirp_pkg;

  // one signed I or Q sample as it leaves the NCO or ADC
  typedef logic signed [15:0] sample_t;

  // packed pair, I in the upper half
  typedef logic [31:0] iq_t;

  // one output word {upper, lower}
  typedef logic [63:0] word_t;

  // sample counter, global counter low half, chirp setup values
  typedef logic [31:0] count_t;

  // NCO phase accumulator and tuning word
  typedef logic [31:0] phase_t;

  // per-half source select
  typedef logic [1:0] route_t;

  // adc I/Q pair
  localparam route_t route_adc        = 2'd0;
  // dac I/Q pair
  localparam route_t route_dac        = 2'd1;
  // running count of written samples
  localparam route_t route_adc_count  = 2'd2;
  // free-running cycle counter
  localparam route_t route_glbl_count = 2'd3;

  // chirp sequencing
  typedef enum logic [1:0] {
    chirp_idle,
    chirp_armed,
    chirp_run,
    chirp_done
  } chirp_state_e;

endpackage
